// File: Makefile
TOP = tb_dbus_mem_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 -f src.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: axi_scratch_ram.sv
`timescale 1ns/1ns

module axi_scratch_ram (
	input  logic                              clk,
	input  logic                              rst,
	// Read address
	input  logic                              arvalid,
	output logic                              arready,
	input  logic [31:0]                       araddr,
	input  logic [dbus_pkg::AXI_ID_WIDTH-1:0] arid,
	// Write address
	input  logic                              awvalid,
	output logic                              awready,
	input  logic [31:0]                       awaddr,
	input  logic [dbus_pkg::AXI_ID_WIDTH-1:0] awid,
	// Write data
	input  logic                              wvalid,
	output logic                              wready,
	input  logic [31:0]                       wdata,
	input  logic [3:0]                        wstrb,
	// Read data
	output logic                              rvalid,
	input  logic                              rready,
	output logic [31:0]                       rdata,
	output logic [dbus_pkg::AXI_ID_WIDTH-1:0] rid,
	output logic                              rlast,
	// Write response
	output logic                              bvalid,
	input  logic                              bready,
	output logic [dbus_pkg::AXI_ID_WIDTH-1:0] bid
);
	import dbus_pkg::*;

	enum logic [1:0] {
		S_IDLE,
		S_RDATA,
		S_WDATA,
		S_BRESP
	} state, state_d;

	logic [31:0] mem [RAM_WORDS];

	logic [RAM_INDEX_BITS-1:0] ar_index;
	logic [RAM_INDEX_BITS-1:0] aw_index;
	logic [RAM_INDEX_BITS-1:0] w_index; // target word of the pending write
	logic [AXI_ID_WIDTH-1:0]   id_q;

	logic ar_fire;
	logic aw_fire;
	logic w_fire;

	// Upper address bits dropped here, hence the aliasing
	assign ar_index = araddr[RAM_INDEX_BITS+1:2];
	assign aw_index = awaddr[RAM_INDEX_BITS+1:2];

	assign arready = (state == S_IDLE);
	assign awready = (state == S_IDLE) && !arvalid; // read first on a tie
	assign wready  = (state == S_WDATA);
	assign rvalid  = (state == S_RDATA);
	assign rlast   = rvalid;
	assign bvalid  = (state == S_BRESP);

	assign rid = id_q;
	assign bid = id_q;

	assign ar_fire = arvalid && arready;
	assign aw_fire = awvalid && awready;
	assign w_fire  = wvalid && wready;

	always_comb begin
		state_d = state;
		case (state)
			S_IDLE: begin
				if (ar_fire)
					state_d = S_RDATA;
				else if (aw_fire)
					state_d = S_WDATA;
			end
			S_RDATA: begin
				if (rready)
					state_d = S_IDLE;
			end
			S_WDATA: begin
				if (w_fire)
					state_d = S_BRESP;
			end
			S_BRESP: begin
				if (bready)
					state_d = S_IDLE;
			end
			default: state_d = S_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= S_IDLE;
		else
			state <= state_d;
	end

	// ID and write index of the transaction in flight
	always_ff @(posedge clk) begin
		if (ar_fire) begin
			id_q <= arid;
		end else if (aw_fire) begin
			id_q    <= awid;
			w_index <= aw_index;
		end
	end

	// Word read at the AR handshake, held until rready
	always_ff @(posedge clk) begin
		if (ar_fire)
			rdata <= mem[ar_index];
	end

	// Byte lanes with strobe set only
	always_ff @(posedge clk) begin
		if (w_fire) begin
			for (int i = 0; i < 4; i++) begin
				if (wstrb[i])
					mem[w_index][8*i +: 8] <= wdata[8*i +: 8];
			end
		end
	end

endmodule

// File: dbus_mem_top.sv
`timescale 1ns/1ns

module dbus_mem_top (
	input  logic        clk,
	input  logic        rst,
	input  logic        read,
	input  logic        write,
	input  logic [31:0] address,
	input  logic [31:0] wrdata,
	input  logic [3:0]  byteenable,
	output logic        stall,
	output logic [31:0] rddata
);
	import dbus_pkg::*;

	// AXI between bridge and RAM
	logic                    arvalid;
	logic                    arready;
	logic [31:0]             araddr;
	logic [AXI_ID_WIDTH-1:0] arid;
	logic                    awvalid;
	logic                    awready;
	logic [31:0]             awaddr;
	logic [AXI_ID_WIDTH-1:0] awid;
	logic                    wvalid;
	logic                    wready;
	logic [31:0]             wdata;
	logic [3:0]              wstrb;
	logic                    rvalid;
	logic                    rready;
	logic [31:0]             rdata;
	logic [AXI_ID_WIDTH-1:0] rid;
	logic                    rlast;
	logic                    bvalid;
	logic                    bready;
	logic [AXI_ID_WIDTH-1:0] bid;

	// Length, size, burst and wlast are fixed single-beat values the RAM ignores
	dcache_pass u_dcache_pass (
		.clk        (clk),
		.rst        (rst),
		.read       (read),
		.write      (write),
		.address    (address),
		.wrdata     (wrdata),
		.byteenable (byteenable),
		.stall      (stall),
		.rddata     (rddata),
		.arvalid    (arvalid),
		.arready    (arready),
		.araddr     (araddr),
		.arid       (arid),
		.arlen      (),
		.arsize     (),
		.arburst    (),
		.awvalid    (awvalid),
		.awready    (awready),
		.awaddr     (awaddr),
		.awid       (awid),
		.awlen      (),
		.awsize     (),
		.awburst    (),
		.wvalid     (wvalid),
		.wready     (wready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wlast      (),
		.wid        (),
		.rvalid     (rvalid),
		.rready     (rready),
		.rdata      (rdata),
		.rid        (rid),
		.rlast      (rlast),
		.bvalid     (bvalid),
		.bready     (bready),
		.bid        (bid)
	);

	axi_scratch_ram u_axi_scratch_ram (
		.clk     (clk),
		.rst     (rst),
		.arvalid (arvalid),
		.arready (arready),
		.araddr  (araddr),
		.arid    (arid),
		.awvalid (awvalid),
		.awready (awready),
		.awaddr  (awaddr),
		.awid    (awid),
		.wvalid  (wvalid),
		.wready  (wready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.rvalid  (rvalid),
		.rready  (rready),
		.rdata   (rdata),
		.rid     (rid),
		.rlast   (rlast),
		.bvalid  (bvalid),
		.bready  (bready),
		.bid     (bid)
	);

endmodule

// File: dbus_pkg.sv
package dbus_pkg;

	// AXI ID width on every channel
	// Only the master's single ID of zero is ever used
	localparam int AXI_ID_WIDTH = 4;

	// Burst type encoding, INCR
	localparam logic [1:0] AXI_BURST_INCR = 2'b01;

	// Transfer size encoding for a full 32-bit beat
	localparam logic [2:0] AXI_SIZE_WORD = 3'b010;

	// Scratch RAM geometry
	// The word index comes from address bits [9:2], so the upper address
	// bits are dropped and every address aliases modulo 1 KiB
	localparam int RAM_WORDS = 256;
	localparam int RAM_INDEX_BITS = 8; // log2(RAM_WORDS)

endpackage

// File: dcache_pass.sv
`timescale 1ns/1ns

module dcache_pass (
	input  logic                              clk,
	input  logic                              rst,
	// Core data bus
	input  logic                              read,
	input  logic                              write,
	input  logic [31:0]                       address,
	input  logic [31:0]                       wrdata,
	input  logic [3:0]                        byteenable,
	output logic                              stall,
	output logic [31:0]                       rddata,
	// AXI read address
	output logic                              arvalid,
	input  logic                              arready,
	output logic [31:0]                       araddr,
	output logic [dbus_pkg::AXI_ID_WIDTH-1:0] arid,
	output logic [7:0]                        arlen,
	output logic [2:0]                        arsize,
	output logic [1:0]                        arburst,
	// AXI write address
	output logic                              awvalid,
	input  logic                              awready,
	output logic [31:0]                       awaddr,
	output logic [dbus_pkg::AXI_ID_WIDTH-1:0] awid,
	output logic [7:0]                        awlen,
	output logic [2:0]                        awsize,
	output logic [1:0]                        awburst,
	// AXI write data
	output logic                              wvalid,
	input  logic                              wready,
	output logic [31:0]                       wdata,
	output logic [3:0]                        wstrb,
	output logic                              wlast,
	output logic [dbus_pkg::AXI_ID_WIDTH-1:0] wid,
	// AXI read data
	input  logic                              rvalid,
	output logic                              rready,
	input  logic [31:0]                       rdata,
	input  logic [dbus_pkg::AXI_ID_WIDTH-1:0] rid,
	input  logic                              rlast,
	// AXI write response
	input  logic                              bvalid,
	output logic                              bready,
	input  logic [dbus_pkg::AXI_ID_WIDTH-1:0] bid
);
	import dbus_pkg::*;

	enum logic [2:0] {
		IDLE,
		FINISHED,
		READ_WAIT_AXI,
		WRITE_WAIT_AXI,
		READ,
		WRITE,
		WAIT_BVALID
	} state, state_d;

	// Registered core request
	logic        pipe_read;
	logic        pipe_write;
	logic [31:0] pipe_addr;
	logic [31:0] pipe_wdata;
	logic [3:0]  pipe_byteenable;

	logic [31:0] line_recv; // read word or echoed write data

	// Stall follows the next state so a fresh request stalls at once
	assign stall  = (state_d != IDLE);
	assign rddata = line_recv;

	// Single beat, INCR, fixed ID
	assign arid    = '0;
	assign awid    = '0;
	assign wid     = '0;
	assign arlen   = '0;
	assign awlen   = '0;
	assign arsize  = AXI_SIZE_WORD;
	assign awsize  = AXI_SIZE_WORD;
	assign arburst = AXI_BURST_INCR;
	assign awburst = AXI_BURST_INCR;

	assign araddr = pipe_addr;
	assign awaddr = pipe_addr;
	assign wdata  = pipe_wdata;
	assign wstrb  = pipe_byteenable;

	assign arvalid = (state == READ_WAIT_AXI);
	assign awvalid = (state == WRITE_WAIT_AXI);
	assign wvalid  = (state == WRITE);
	assign wlast   = (state == WRITE); // only beat of the burst
	assign rready  = (state == READ);
	assign bready  = (state == WAIT_BVALID);

	always_comb begin
		state_d = state;
		case (state)
			IDLE: begin
				if (pipe_read) begin // read wins if both are set
					state_d = READ_WAIT_AXI;
				end else if (pipe_write) begin
					state_d = WRITE_WAIT_AXI;
				end
			end
			READ_WAIT_AXI: begin
				if (arready)
					state_d = READ;
			end
			WRITE_WAIT_AXI: begin
				if (awready)
					state_d = WRITE;
			end
			READ: begin
				if (rvalid && rlast)
					state_d = FINISHED;
			end
			WRITE: begin
				if (wready)
					state_d = WAIT_BVALID;
			end
			WAIT_BVALID: begin
				if (bvalid)
					state_d = FINISHED;
			end
			FINISHED: state_d = IDLE;
			default:  state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= IDLE;
		else
			state <= state_d;
	end

	// Request control bits
	always_ff @(posedge clk) begin
		if (rst) begin
			pipe_read  <= 1'b0;
			pipe_write <= 1'b0;
		end else if (!stall) begin
			pipe_read  <= read;
			pipe_write <= write;
		end
	end

	// Request payload, held while stalled
	always_ff @(posedge clk) begin
		if (!stall) begin
			pipe_addr       <= address;
			pipe_wdata      <= wrdata;
			pipe_byteenable <= byteenable;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			line_recv <= '0;
		end else if (state == READ && rvalid) begin
			line_recv <= rdata;
		end else if (state == WRITE && wready) begin
			line_recv <= pipe_wdata; // writes return what was sent
		end
	end

endmodule

// File: src.f
dbus_pkg.sv
dcache_pass.sv
axi_scratch_ram.sv
dbus_mem_top.sv
tb_dbus_mem_top.sv

// File: tb_dbus_mem_top.sv
`timescale 1ns/1ns

module tb_dbus_mem_top;
	import dbus_pkg::*;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 5;
	localparam int NUM_RANDOM   = 40;
	localparam int MAX_ROWS     = 64;

	logic        clk;
	logic        rst;
	logic        read;
	logic        write;
	logic [31:0] address;
	logic [31:0] wrdata;
	logic [3:0]  byteenable;
	logic        stall;
	logic [31:0] rddata;

	// One stimulus row per bus transaction
	bit          op_tab   [MAX_ROWS]; // 1 for write
	logic [31:0] addr_tab [MAX_ROWS];
	logic [3:0]  be_tab   [MAX_ROWS];
	logic [31:0] data_tab [MAX_ROWS];
	logic [31:0] exp_tab  [MAX_ROWS];
	int          num_rows;
	bit          table_ready;

	// Reference memory and which words hold known data
	logic [31:0] mem_model [RAM_WORDS];
	bit          written   [RAM_WORDS];

	dbus_mem_top uut (
		.clk        (clk),
		.rst        (rst),
		.read       (read),
		.write      (write),
		.address    (address),
		.wrdata     (wrdata),
		.byteenable (byteenable),
		.stall      (stall),
		.rddata     (rddata)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Word slot of a byte address with the RAM wrapping every RAM_WORDS words
	function automatic int word_index(input logic [31:0] addr);
		return int'((addr >> 2) % RAM_WORDS);
	endfunction

	task automatic check(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			$display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
			$display("Some tests failed");
			$fatal(1, "Value mismatch on %s", name);
		end
	endtask

	// Append one transaction and work out its expected rddata from the model
	task automatic add_row(input bit is_write, input logic [31:0] addr,
			input logic [3:0] be, input logic [31:0] data);
		int          idx;
		logic [31:0] lane_mask;
		idx = word_index(addr);
		lane_mask = {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
		op_tab[num_rows]   = is_write;
		addr_tab[num_rows] = addr;
		be_tab[num_rows]   = be;
		data_tab[num_rows] = data;
		if (is_write) begin
			mem_model[idx] = (mem_model[idx] & ~lane_mask) | (data & lane_mask);
			written[idx] = 1'b1;
			exp_tab[num_rows] = data; // write returns the sent word
		end else begin
			exp_tab[num_rows] = mem_model[idx];
		end
		num_rows++;
	endtask

	task automatic build_table();
		logic [31:0] hi;
		logic [31:0] sel;
		logic [31:0] data;
		logic [31:0] addr;
		int          idx;
		bit          is_write;
		logic [3:0]  be;
		num_rows = 0;
		add_row(1'b1, 32'h0000_0100, 4'hf, 32'hdead_beef);
		add_row(1'b0, 32'h0000_0100, 4'hf, 32'h0000_0000);
		add_row(1'b1, 32'h0000_0104, 4'hf, 32'h1122_3344);
		add_row(1'b1, 32'h0000_0104, 4'b0101, 32'haabb_ccdd); // lanes 0 and 2
		add_row(1'b0, 32'h0000_0104, 4'hf, 32'h0000_0000);
		add_row(1'b1, 32'h0000_0104, 4'b1000, 32'h5566_7788);
		add_row(1'b0, 32'h0000_0104, 4'hf, 32'h0000_0000);
		add_row(1'b1, 32'h0000_0208, 4'hf, 32'hcafe_f00d);
		add_row(1'b0, 32'h0000_0608, 4'hf, 32'h0000_0000); // same word plus 1 KiB
		add_row(1'b0, 32'h8000_0208, 4'hf, 32'h0000_0000);
		add_row(1'b1, 32'h0000_03fc, 4'hf, 32'h0bad_c0de);
		add_row(1'b0, 32'hffff_fffc, 4'hf, 32'h0000_0000);
		add_row(1'b1, 32'h0000_0504, 4'b0011, 32'h9999_aaaa); // aliases 0x104
		add_row(1'b0, 32'h0000_0104, 4'hf, 32'h0000_0000);
		// Word stays as it was with no lanes enabled
		add_row(1'b1, 32'h0000_0100, 4'b0000, 32'h1234_5678);
		add_row(1'b0, 32'h0000_0100, 4'hf, 32'h0000_0000);

		// Random block kept to 16 words so reads hit written data
		for (int n = 0; n < NUM_RANDOM; n++) begin
			hi   = $urandom();
			sel  = $urandom();
			data = $urandom();
			addr = {hi[31:10], 4'h3, sel[3:0], 2'b00};
			idx  = word_index(addr);
			is_write = sel[8] || !written[idx];
			be = written[idx] ? sel[7:4] : 4'hf;
			add_row(is_write, addr, be, data);
		end
	endtask

	task automatic apply_row(input int i);
		read       <= !op_tab[i];
		write      <= op_tab[i];
		address    <= addr_tab[i];
		wrdata     <= data_tab[i];
		byteenable <= be_tab[i];
	endtask

	// Junk on the bus while stalled that the bridge must ignore
	task automatic scramble_inputs();
		logic [31:0] r;
		r = $urandom();
		read       <= r[0];
		write      <= r[1];
		byteenable <= r[7:4];
		address    <= $urandom();
		wrdata     <= $urandom();
	endtask

	task automatic release_bus();
		read  <= 1'b0;
		write <= 1'b0;
	endtask

	initial begin
		rst        = 1'b1;
		read       = 1'b0;
		write      = 1'b0;
		address    = '0;
		wrdata     = '0;
		byteenable = '0;
		table_ready = 1'b0;
		void'($urandom(98));
		build_table();
		table_ready = 1'b1;

		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check("stall", {31'b0, stall}, 32'd0);
		check("rddata", rddata, 32'd0);

		@(posedge clk);
		apply_row(0);
		for (int i = 0; i < num_rows; i++) begin
			@(posedge clk); // row i taken by the bridge here
			scramble_inputs();
			@(negedge clk);
			check("stall", {31'b0, stall}, 32'd1);
			@(posedge clk);
			// Next row waits on the bus so it goes in the cycle stall drops
			if (i + 1 < num_rows)
				apply_row(i + 1);
			else
				release_bus();
			do @(negedge clk); while (stall);
			check("rddata", rddata, exp_tab[i]);
		end

		$display("All tests passed");
		$finish;
	end

	// Each transaction needs well under 20 cycles
	initial begin
		wait (table_ready);
		#((num_rows * 20 + RESET_CYCLES + 4) * CLK_PERIOD);
		$display("Some tests failed");
		$fatal(1, "Timeout, the bus did not finish the transactions in time");
	end

endmodule
